// File: ps2_mouse.f
ps2_mouse_pkg.sv
ps2_timebase.sv
ps2_rx.sv
ps2_tx.sv
ps2_mouse_ctrl.sv
ps2_mouse_top.sv
tb_clock_gen.sv
ps2_mouse_model.sv
ps2_mouse_tb.sv

// File: ps2_mouse_vectors.txt
// device id, report count, expected FE commands
// then per report: status x y corrupt_flag withhold_credit_flag
00
07
01
08 05 FB 00 00
28 F0 10 01 00
18 7F 80 00 00
09 01 02 00 01
0A 33 44 00 01
38 A5 5A 00 00
08 11 22 00 00

// File: ps2_mouse_tb.sv
module ps2_mouse_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import ps2_mouse_pkg::*;

	logic       qzt_clk;
	logic       arst_n;
	logic       start;
	logic       report_credit;
	tri1        ps2_clk;
	tri1        ps2_data;
	logic [7:0] status_byte;
	logic [7:0] x_byte;
	logic [7:0] y_byte;
	logic       report_valid;
	logic [7:0] device_id;
	logic       init_done;
	logic       link_error;
	// id, report count, resend count, then five words per report
	logic [7:0] vec [0:37];
	int         credits;

	tb_clock_gen clock_gen (
		.qzt_clk (qzt_clk),
		.arst_n  (arst_n)
	);

	ps2_mouse_top dut (
		.qzt_clk       (qzt_clk),
		.arst_n        (arst_n),
		.start         (start),
		.report_credit (report_credit),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.status_byte   (status_byte),
		.x_byte        (x_byte),
		.y_byte        (y_byte),
		.report_valid  (report_valid),
		.device_id     (device_id),
		.init_done     (init_done),
		.link_error    (link_error)
	);

	ps2_mouse_model mouse (
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
				name, expected, actual));
	endtask

	//////////////////////////////
	// bounded waits
	//////////////////////////////

	task automatic wait_for_reset_release(input int limit);
		int n;
		n = 0;
		while (arst_n !== 1'b1) begin
			if (n > limit)
				abort_run("timeout waiting for reset release");
			@(posedge qzt_clk);
			n++;
		end
	endtask

	// outputs sampled on the falling edge
	task automatic wait_for_init(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge qzt_clk);
			n++;
			if (n > limit)
				abort_run("timeout waiting for init_done");
		end while (init_done !== 1'b1);
	endtask

	task automatic wait_for_report(input int limit, input string what);
		int n;
		n = 0;
		do begin
			@(negedge qzt_clk);
			n++;
			if (n > limit)
				abort_run($sformatf("timeout waiting for %s", what));
		end while (report_valid !== 1'b1);
	endtask

	task automatic expect_quiet(input int cycles, input string what);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge qzt_clk);
			check_value(what, 0, report_valid);
		end
	endtask

	// inputs change 2 ns after the rising edge
	task automatic pulse_start();
		@(posedge qzt_clk);
		#2 start = 1'b1;
		@(posedge qzt_clk);
		#2 start = 1'b0;
	endtask

	task automatic return_credit();
		@(posedge qzt_clk);
		#2 report_credit = 1'b1;
		@(posedge qzt_clk);
		#2 report_credit = 1'b0;
		credits++;
	endtask

	initial begin : run_tests
		int n_reports;
		int resends_expected;
		int corrupt_seen;
		int held;
		int base;
		int i;
		start         = 1'b0;
		report_credit = 1'b0;
		credits       = MAX_CREDITS;
		corrupt_seen  = 0;
		held          = 0;
		$readmemh("ps2_mouse_vectors.txt", vec);
		n_reports        = vec[1];
		resends_expected = vec[2];
		mouse.set_device_id(vec[0]);
		for (i = 0; i < n_reports; i++) begin
			base = 3 + 5 * i;
			mouse.add_report(vec[base], vec[base + 1], vec[base + 2], vec[base + 3][0]);
		end

		// quiet outputs and released lines out of reset
		wait_for_reset_release(100);
		@(negedge qzt_clk);
		check_value("report_valid after reset", 0, report_valid);
		check_value("init_done after reset", 0, init_done);
		check_value("link_error after reset", 0, link_error);
		check_value("ps2_clk after reset", 1, ps2_clk);
		check_value("ps2_data after reset", 1, ps2_data);

		// init sequence
		pulse_start();
		wait_for_init(1_000_000);
		check_value("commands during init", 3, mouse.cmd_count);
		check_value("first command", 8'hF2, mouse.cmd_log[0]);
		check_value("second command", 8'hEA, mouse.cmd_log[1]);
		check_value("third command", 8'hF4, mouse.cmd_log[2]);
		check_value("device_id", vec[0], device_id);
		check_value("link_error after init", 0, link_error);

		// reports in vector order, resend and credit stalls on the way
		for (i = 0; i < n_reports; i++) begin
			base = 3 + 5 * i;
			wait_for_report(500_000, $sformatf("report %0d", i));
			credits--;
			check_value($sformatf("report %0d status_byte", i), vec[base], status_byte);
			check_value($sformatf("report %0d x_byte", i), vec[base + 1], x_byte);
			check_value($sformatf("report %0d y_byte", i), vec[base + 2], y_byte);
			if (vec[base + 3][0])
				corrupt_seen++;
			// a corrupted copy would have shown up before the FE
			check_value($sformatf("report %0d resends so far", i), corrupt_seen,
				mouse.resend_count);
			if (vec[base + 4][0])
				held++;
			else
				return_credit();
			if (credits == 0 && i < n_reports - 1) begin
				check_value("inhibit before credits ran out", 0, mouse.inhibit_seen);
				// 6 ms with the next report waiting in the mouse
				expect_quiet(150_000, "report while out of credit");
				check_value("clock inhibit seen by mouse", 1, mouse.inhibit_seen);
				while (held > 0) begin
					return_credit();
					held--;
				end
			end
		end

		expect_quiet(100_000, "extra report after the last vector");
		check_value("resend commands", resends_expected, mouse.resend_count);
		check_value("total commands", 3 + resends_expected, mouse.cmd_count);
		check_value("bad command frames", 0, mouse.cmd_errors);
		check_value("link_error at end", 0, link_error);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: ps2_mouse_model.sv
module ps2_mouse_model (
	inout tri ps2_clk,
	inout tri ps2_data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic       clk_drv = 1'b0;
	logic       data_drv = 1'b0;
	logic [7:0] id_byte = 8'h00;
	logic [7:0] rpt_status [0:15];
	logic [7:0] rpt_x [0:15];
	logic [7:0] rpt_y [0:15];
	logic       rpt_bad [0:15];
	int         rpt_count = 0;
	int         rpt_sent = 0;
	int         last_idx = 0;
	logic       reporting = 1'b0;
	logic       resend_pending = 1'b0;
	logic       inhibit_seen = 1'b0;
	logic [7:0] cmd_log [0:31];
	int         cmd_count = 0;
	int         resend_count = 0;
	int         cmd_errors = 0;

	// open drain, same as the host side
	assign ps2_clk  = clk_drv ? 1'b0 : 1'bz;
	assign ps2_data = data_drv ? 1'b0 : 1'bz;

	task automatic set_device_id(input logic [7:0] id);
		id_byte = id;
	endtask

	task automatic add_report(input logic [7:0] status, input logic [7:0] x,
		input logic [7:0] y, input logic bad);
		rpt_status[rpt_count] = status;
		rpt_x[rpt_count]      = x;
		rpt_y[rpt_count]      = y;
		rpt_bad[rpt_count]    = bad;
		rpt_count++;
	endtask

	//////////////////////////////
	// device to host
	//////////////////////////////

	// 40 us high, 40 us low per bit, about 12.5 kHz
	task automatic send_byte(input logic [7:0] b, input logic flip_parity);
		logic [10:0] frame;
		int          k;
		// stop, odd parity, data lsb first, start
		frame = {1'b1, (~^b) ^ flip_parity, b, 1'b0};
		for (k = 0; k < 11; k++) begin
			data_drv = !frame[k];
			#40000;
			clk_drv = 1'b1;
			#40000;
			clk_drv = 1'b0;
		end
		data_drv = 1'b0;
		#40000;
	endtask

	// corruption only ever hits the x byte
	task automatic send_report(input int idx, input logic flip);
		send_byte(rpt_status[idx], 1'b0);
		#100000;
		send_byte(rpt_x[idx], flip);
		#100000;
		send_byte(rpt_y[idx], 1'b0);
	endtask

	//////////////////////////////
	// host to device
	//////////////////////////////

	// long low with data high is an inhibit, rts is much shorter
	task automatic await_clock_release(output logic host_rts);
		int low_us;
		low_us = 0;
		while (ps2_clk !== 1'b1 && low_us < 50000) begin
			#1000;
			low_us++;
			if (ps2_data === 1'b1 && low_us > 400)
				inhibit_seen = 1'b1;
		end
		// host has the start bit on data when it lets the clock go
		host_rts = (ps2_data === 1'b0);
	endtask

	task automatic take_command();
		logic [9:0] bits;
		int         k;
		#40000;
		// data, parity, stop, read late in each low phase
		for (k = 0; k < 10; k++) begin
			clk_drv = 1'b1;
			#40000;
			bits[k] = (ps2_data === 1'b1);
			clk_drv = 1'b0;
			#40000;
		end
		// ack bit, data low across one more clock
		data_drv = 1'b1;
		#20000;
		clk_drv = 1'b1;
		#40000;
		clk_drv = 1'b0;
		#20000;
		data_drv = 1'b0;
		cmd_log[cmd_count] = bits[7:0];
		cmd_count++;
		if (bits[9] !== 1'b1 || (^bits[8:0]) !== 1'b1)
			cmd_errors++;
		#200000;
		send_byte(8'hFA, 1'b0);
		case (bits[7:0])
			8'hF2: begin
				#200000;
				send_byte(id_byte, 1'b0);
			end
			8'hF4: reporting = 1'b1;
			8'hFE: begin
				resend_count++;
				resend_pending = 1'b1;
			end
			default: ;
		endcase
	endtask

	// bus must be idle 100 us before a report goes out
	initial begin : bus_loop
		logic host_rts;
		int   idle_us;
		idle_us = 0;
		forever begin
			if (ps2_clk !== 1'b1) begin
				await_clock_release(host_rts);
				idle_us = 0;
				if (host_rts)
					take_command();
			end else if (idle_us >= 100 &&
				(resend_pending || (reporting && rpt_sent < rpt_count))) begin
				if (resend_pending) begin
					// repeat goes out clean
					resend_pending = 1'b0;
					send_report(last_idx, 1'b0);
				end else begin
					last_idx = rpt_sent;
					rpt_sent++;
					send_report(last_idx, rpt_bad[last_idx]);
				end
				idle_us = 0;
			end else begin
				#1000;
				idle_us++;
			end
		end
	end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
	output logic qzt_clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period, 25 MHz
	initial begin
		qzt_clk = 1'b0;
		forever #20 qzt_clk = ~qzt_clk;
	end

	// reset low for ten rising edges, released just after an edge
	initial begin : reset_seq
		arst_n = 1'b0;
		repeat (10) @(posedge qzt_clk);
		#2;
		arst_n = 1'b1;
	end

endmodule

// File: ps2_mouse_top.sv
module ps2_mouse_top (
	input  logic       qzt_clk,
	input  logic       arst_n,
	input  logic       start,
	input  logic       report_credit,
	inout  tri         ps2_clk,
	inout  tri         ps2_data,
	output logic [7:0] status_byte,
	output logic [7:0] x_byte,
	output logic [7:0] y_byte,
	output logic       report_valid,
	output logic [7:0] device_id,
	output logic       init_done,
	output logic       link_error
);
	import ps2_mouse_pkg::*;

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       ps2_clk_in;
	logic       ps2_data_in;
	logic       ps2_clk_low;
	logic       ps2_data_low;
	logic       sample_en;
	logic       tick_en;
	logic       timer_start;
	logic [7:0] timer_ticks;
	logic       timer_done;
	logic       tx_start;
	ps2_cmd_e   tx_byte;
	logic       tx_clk_low;
	logic       tx_data_low;
	logic       tx_busy;
	logic       tx_done;
	logic       tx_nack;
	logic       rx_enable;
	logic       rx_busy;
	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       rx_frame_ok;
	logic       inhibit_low;

	//////////////////////////////
	// pads
	//////////////////////////////

	// open drain, only ever pulled low
	assign ps2_clk_low  = tx_clk_low | inhibit_low;
	assign ps2_data_low = tx_data_low;
	assign ps2_clk  = ps2_clk_low ? 1'b0 : 1'bz;
	assign ps2_data = ps2_data_low ? 1'b0 : 1'bz;

	// two-flop synchronizers, idle high
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	assign ps2_clk_in  = clk_sync[1];
	assign ps2_data_in = data_sync[1];

	ps2_timebase u_timebase (
		.qzt_clk     (qzt_clk),
		.arst_n      (arst_n),
		.timer_start (timer_start),
		.timer_ticks (timer_ticks),
		.sample_en   (sample_en),
		.tick_en     (tick_en),
		.timer_done  (timer_done)
	);

	ps2_rx u_rx (
		.qzt_clk     (qzt_clk),
		.arst_n      (arst_n),
		.sample_en   (sample_en),
		.enable      (rx_enable),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.rx_busy     (rx_busy),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.rx_frame_ok (rx_frame_ok)
	);

	ps2_tx u_tx (
		.qzt_clk     (qzt_clk),
		.arst_n      (arst_n),
		.sample_en   (sample_en),
		.tick_en     (tick_en),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.clk_low     (tx_clk_low),
		.data_low    (tx_data_low),
		.tx_busy     (tx_busy),
		.tx_done     (tx_done),
		.tx_nack     (tx_nack)
	);

	ps2_mouse_ctrl u_ctrl (
		.qzt_clk       (qzt_clk),
		.arst_n        (arst_n),
		.start         (start),
		.report_credit (report_credit),
		.tx_busy       (tx_busy),
		.tx_done       (tx_done),
		.tx_nack       (tx_nack),
		.rx_busy       (rx_busy),
		.rx_valid      (rx_valid),
		.rx_frame_ok   (rx_frame_ok),
		.rx_byte       (rx_byte),
		.timer_done    (timer_done),
		.tx_start      (tx_start),
		.tx_byte       (tx_byte),
		.rx_enable     (rx_enable),
		.timer_start   (timer_start),
		.timer_ticks   (timer_ticks),
		.inhibit_low   (inhibit_low),
		.status_byte   (status_byte),
		.x_byte        (x_byte),
		.y_byte        (y_byte),
		.report_valid  (report_valid),
		.device_id     (device_id),
		.init_done     (init_done),
		.link_error    (link_error)
	);

endmodule

// File: ps2_mouse_ctrl.sv
module ps2_mouse_ctrl (
	input  logic                    qzt_clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic                    report_credit,
	input  logic                    tx_busy,
	input  logic                    tx_done,
	input  logic                    tx_nack,
	input  logic                    rx_busy,
	input  logic                    rx_valid,
	input  logic                    rx_frame_ok,
	input  logic [7:0]              rx_byte,
	input  logic                    timer_done,
	output logic                    tx_start,
	output ps2_mouse_pkg::ps2_cmd_e tx_byte,
	output logic                    rx_enable,
	output logic                    timer_start,
	output logic [7:0]              timer_ticks,
	output logic                    inhibit_low,
	output logic [7:0]              status_byte,
	output logic [7:0]              x_byte,
	output logic [7:0]              y_byte,
	output logic                    report_valid,
	output logic [7:0]              device_id,
	output logic                    init_done,
	output logic                    link_error
);
	import ps2_mouse_pkg::*;

	ctrl_state_e         state;
	logic                start_q;
	logic [1:0]          cmd_idx;
	logic                tx_pending;
	logic [1:0]          byte_cnt;
	logic                frame_bad;
	logic                skip_ack;
	logic [7:0]          hold_status;
	logic [7:0]          hold_x;
	logic [CREDIT_W-1:0] credit_cnt;
	int                  credit_next;
	logic                ack_ok;
	logic                listening;
	logic                stray_ack;
	logic                third_ok;
	logic                init_fail;
	logic                cmd_complete;

	// init command order
	function automatic ps2_cmd_e init_cmd(input logic [1:0] idx);
		case (idx)
			2'd0:    return CMD_GET_ID;
			2'd1:    return CMD_STREAM;
			default: return CMD_ENABLE;
		endcase
	endfunction

	assign rx_enable = !tx_busy;
	assign ack_ok    = rx_frame_ok && (rx_byte == ACK_BYTE);
	assign listening = (state == LISTEN) || (state == INHIBIT);
	// ack answering our resend, dropped once
	assign stray_ack = skip_ack && (byte_cnt == 2'd0) && ack_ok;
	assign third_ok  = rx_frame_ok && !frame_bad && (credit_cnt != '0);

	assign init_fail = (state == SEND && tx_done && tx_nack) ||
		(state == WAIT_ACK && (rx_valid ? !ack_ok : timer_done)) ||
		(state == WAIT_ID && (rx_valid ? !rx_frame_ok : timer_done));
	assign cmd_complete = (state == WAIT_ACK && rx_valid && ack_ok && cmd_idx != 2'd0) ||
		(state == WAIT_ID && rx_valid && rx_frame_ok);

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= IDLE;
			start_q      <= 1'b0;
			cmd_idx      <= '0;
			tx_pending   <= 1'b0;
			tx_start     <= 1'b0;
			tx_byte      <= CMD_GET_ID;
			timer_start  <= 1'b0;
			timer_ticks  <= '0;
			byte_cnt     <= '0;
			frame_bad    <= 1'b0;
			skip_ack     <= 1'b0;
			inhibit_low  <= 1'b0;
			report_valid <= 1'b0;
			init_done    <= 1'b0;
			link_error   <= 1'b0;
		end else begin
			start_q      <= start;
			tx_start     <= 1'b0;
			timer_start  <= 1'b0;
			report_valid <= 1'b0;
			// bus held off between frames while out of credit
			inhibit_low  <= (state == INHIBIT) && !rx_busy && !tx_busy;

			// one transfer per visit to SEND or RESEND
			if ((state == SEND || state == RESEND) && !tx_busy && !tx_pending) begin
				tx_start   <= 1'b1;
				tx_byte    <= (state == RESEND) ? CMD_RESEND : init_cmd(cmd_idx);
				tx_pending <= 1'b1;
			end

			case (state)
				IDLE: begin
					if (start && !start_q) begin
						cmd_idx   <= '0;
						init_done <= 1'b0;
						state     <= SEND;
					end
				end
				SEND: begin
					if (tx_done) begin
						tx_pending  <= 1'b0;
						timer_start <= 1'b1;
						timer_ticks <= 8'(ACK_TIMEOUT_TICKS);
						state       <= WAIT_ACK;
					end
				end
				WAIT_ACK: begin
					// identify is followed by the id byte
					if (rx_valid && ack_ok && cmd_idx == 2'd0) begin
						timer_start <= 1'b1;
						state       <= WAIT_ID;
					end
				end
				LISTEN, INHIBIT: begin
					state <= (credit_cnt == '0) ? INHIBIT : LISTEN;
					if (rx_valid) begin
						skip_ack <= 1'b0;
						if (!stray_ack && byte_cnt == 2'd2) begin
							byte_cnt  <= '0;
							frame_bad <= 1'b0;
							if (third_ok) begin
								report_valid <= 1'b1;
								state        <= PUBLISH;
							end else begin
								state <= RESEND;
							end
						end else if (!stray_ack) begin
							// gap limit runs from the first byte
							if (byte_cnt == 2'd0) begin
								timer_start <= 1'b1;
								timer_ticks <= 8'(REPORT_TIMEOUT_TICKS);
							end
							byte_cnt  <= byte_cnt + 2'd1;
							frame_bad <= frame_bad | !rx_frame_ok;
						end
					end else if (timer_done && byte_cnt != 2'd0) begin
						// partial report, resync on the next one
						byte_cnt  <= '0;
						frame_bad <= 1'b0;
					end
				end
				PUBLISH: state <= LISTEN;
				RESEND: begin
					if (tx_done) begin
						tx_pending <= 1'b0;
						skip_ack   <= 1'b1;
						state      <= LISTEN;
					end
				end
				// WAIT_ID handled below
				default: ;
			endcase

			if (init_fail) begin
				link_error <= 1'b1;
				state      <= IDLE;
			end
			if (cmd_complete) begin
				if (cmd_idx == 2'd2) begin
					init_done <= 1'b1;
					state     <= LISTEN;
				end else begin
					cmd_idx <= cmd_idx + 2'd1;
					state   <= SEND;
				end
			end
		end
	end

	//////////////////////////////
	// report and id bytes
	//////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (state == WAIT_ID && rx_valid && rx_frame_ok)
			device_id <= rx_byte;
		if (listening && rx_valid && !stray_ack) begin
			case (byte_cnt)
				2'd0: hold_status <= rx_byte;
				2'd1: hold_x <= rx_byte;
				default: begin
					// outputs change only with a published report
					if (third_ok) begin
						status_byte <= hold_status;
						x_byte      <= hold_x;
						y_byte      <= rx_byte;
					end
				end
			endcase
		end
	end

	// credits, spent on publish and returned by the consumer
	always_comb begin
		credit_next = int'(credit_cnt);
		if (state == PUBLISH)
			credit_next = credit_next - 1;
		if (report_credit && credit_next < MAX_CREDITS)
			credit_next = credit_next + 1;
	end

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n)
			credit_cnt <= CREDIT_W'(MAX_CREDITS);
		else
			credit_cnt <= CREDIT_W'(credit_next);
	end

endmodule

// File: ps2_tx.sv
module ps2_tx (
	input  logic                   qzt_clk,
	input  logic                   arst_n,
	input  logic                   sample_en,
	input  logic                   tick_en,
	input  logic                   tx_start,
	input  ps2_mouse_pkg::ps2_cmd_e tx_byte,
	input  logic                   ps2_clk_in,
	input  logic                   ps2_data_in,
	output logic                   clk_low,
	output logic                   data_low,
	output logic                   tx_busy,
	output logic                   tx_done,
	output logic                   tx_nack
);
	import ps2_mouse_pkg::*;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_RTS,
		TX_START,
		TX_BITS,
		TX_FINISH
	} tx_state_e;

	tx_state_e  state;
	logic       clk_prev;
	logic       fall;
	logic [3:0] bit_cnt;
	logic [7:0] tick_cnt;
	logic       nack;
	// stop, parity, data
	logic [9:0] shift;

	assign fall = sample_en && clk_prev && !ps2_clk_in;
	assign tx_busy = (state != TX_IDLE);

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= TX_IDLE;
			clk_prev <= 1'b1;
			bit_cnt  <= '0;
			tick_cnt <= '0;
			clk_low  <= 1'b0;
			data_low <= 1'b0;
			nack     <= 1'b0;
			tx_done  <= 1'b0;
			tx_nack  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			tx_nack <= 1'b0;
			if (sample_en)
				clk_prev <= ps2_clk_in;
			if (tick_en)
				tick_cnt <= tick_cnt + 8'd1;

			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						// request to send, clock low first
						clk_low  <= 1'b1;
						tick_cnt <= '0;
						bit_cnt  <= '0;
						state    <= TX_RTS;
					end
				end
				TX_RTS: begin
					if (tick_cnt == 8'(RTS_TICKS)) begin
						// start bit goes out before the clock is let go
						data_low <= 1'b1;
						tick_cnt <= '0;
						state    <= TX_START;
					end
				end
				TX_START: begin
					clk_low <= 1'b0;
					state   <= TX_BITS;
				end
				TX_BITS: begin
					if (fall) begin
						if (bit_cnt == 4'd10) begin
							// device pulls data low to acknowledge
							nack  <= ps2_data_in;
							state <= TX_FINISH;
						end else begin
							// next bit set up while the device clock is low
							data_low <= !shift[0];
							bit_cnt  <= bit_cnt + 4'd1;
						end
					end
				end
				TX_FINISH: begin
					// wait for the device to let both lines go
					if (ps2_clk_in && ps2_data_in) begin
						tx_done <= 1'b1;
						tx_nack <= nack;
						state   <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase

			// silent or stuck device ends the transfer as a nack
			if ((state == TX_BITS || state == TX_FINISH) &&
				tick_cnt == 8'(ACK_TIMEOUT_TICKS)) begin
				data_low <= 1'b0;
				tx_done  <= 1'b1;
				tx_nack  <= 1'b1;
				state    <= TX_IDLE;
			end
		end
	end

	// frame shifter, odd parity
	always_ff @(posedge qzt_clk) begin
		if (state == TX_IDLE && tx_start)
			shift <= {1'b1, ~^tx_byte, tx_byte};
		else if (state == TX_BITS && fall && bit_cnt != 4'd10)
			shift <= shift >> 1;
	end

endmodule

// File: ps2_rx.sv
module ps2_rx (
	input  logic       qzt_clk,
	input  logic       arst_n,
	input  logic       sample_en,
	input  logic       enable,
	input  logic       ps2_clk_in,
	input  logic       ps2_data_in,
	output logic       rx_busy,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	output logic       rx_frame_ok
);

	logic        clk_prev;
	logic        fall;
	logic [3:0]  bit_cnt;
	logic [3:0]  gap_cnt;
	logic [10:0] frame;
	logic [10:0] frame_next;

	// falling edge seen at the sample strobe
	assign fall = sample_en && clk_prev && !ps2_clk_in;
	// lsb first, so new bits enter at the top
	assign frame_next = {ps2_data_in, frame[10:1]};
	assign rx_busy = (bit_cnt != 4'd0);

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_prev    <= 1'b1;
			bit_cnt     <= '0;
			gap_cnt     <= '0;
			rx_valid    <= 1'b0;
			rx_frame_ok <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (sample_en)
				clk_prev <= ps2_clk_in;
			// about 300 us without an edge drops a torn frame
			if (!enable || gap_cnt == 4'hf) begin
				bit_cnt <= '0;
				gap_cnt <= '0;
			end else if (fall) begin
				gap_cnt <= '0;
				if (bit_cnt == 4'd0) begin
					// data high here is a host inhibit, not a start bit
					if (!ps2_data_in)
						bit_cnt <= 4'd1;
				end else if (bit_cnt == 4'd10) begin
					// stop bit in hand
					bit_cnt     <= '0;
					rx_valid    <= 1'b1;
					// start low, stop high, odd parity over data and parity
					rx_frame_ok <= !frame_next[0] && frame_next[10] && (^frame_next[9:1]);
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (sample_en && rx_busy) begin
				gap_cnt <= gap_cnt + 4'd1;
			end
		end
	end

	//////////////////////////////
	// frame shifter
	//////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (fall)
			frame <= frame_next;
		if (fall && bit_cnt == 4'd10)
			rx_byte <= frame_next[8:1];
	end

endmodule

// File: ps2_timebase.sv
module ps2_timebase (
	input  logic       qzt_clk,
	input  logic       arst_n,
	input  logic       timer_start,
	input  logic [7:0] timer_ticks,
	output logic       sample_en,
	output logic       tick_en,
	output logic       timer_done
);
	import ps2_mouse_pkg::*;

	logic [$clog2(SAMPLE_DIV)-1:0] sample_cnt;
	logic [$clog2(TICK_DIV)-1:0]   tick_cnt;
	logic [7:0]                    remaining;
	logic                          running;

	// line sample strobe, one cycle wide
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			sample_cnt <= '0;
			sample_en  <= 1'b0;
		end else if (int'(sample_cnt) == SAMPLE_DIV - 1) begin
			sample_cnt <= '0;
			sample_en  <= 1'b1;
		end else begin
			sample_cnt <= sample_cnt + 1'b1;
			sample_en  <= 1'b0;
		end
	end

	// 100 us strobe
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
			tick_en  <= 1'b0;
		end else if (int'(tick_cnt) == TICK_DIV - 1) begin
			tick_cnt <= '0;
			tick_en  <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick_en  <= 1'b0;
		end
	end

	//////////////////////////////
	// one-shot countdown
	//////////////////////////////

	// a new start reloads, even mid count
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			remaining  <= '0;
			running    <= 1'b0;
			timer_done <= 1'b0;
		end else begin
			timer_done <= 1'b0;
			if (timer_start) begin
				remaining <= timer_ticks;
				running   <= 1'b1;
			end else if (running && tick_en) begin
				// last tick ends the run
				if (remaining <= 8'd1) begin
					running    <= 1'b0;
					timer_done <= 1'b1;
				end else begin
					remaining <= remaining - 8'd1;
				end
			end
		end
	end

endmodule

// File: ps2_mouse_pkg.sv
package ps2_mouse_pkg;

	//////////////////////////////
	// timebase
	//////////////////////////////

	// 25 MHz qzt_clk, 50 kHz line sampling
	localparam int SAMPLE_DIV = 500;
	// 100 us timer tick
	localparam int TICK_DIV = 2500;

	//////////////////////////////
	// protocol timing in ticks
	//////////////////////////////

	// clock held low before a host frame
	localparam int RTS_TICKS = 2;
	// device answer window, 7 ms
	localparam int ACK_TIMEOUT_TICKS = 70;
	// longest gap inside one movement report
	localparam int REPORT_TIMEOUT_TICKS = 100;

	// report flow control
	localparam int MAX_CREDITS = 2;
	localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);

	// host commands, plus the device ack value
	typedef enum logic [7:0] {
		CMD_GET_ID = 8'hF2,
		CMD_STREAM = 8'hEA,
		CMD_ENABLE = 8'hF4,
		CMD_RESEND = 8'hFE,
		ACK_BYTE   = 8'hFA
	} ps2_cmd_e;

	// controller FSM
	typedef enum logic [2:0] {
		IDLE,
		SEND,
		WAIT_ACK,
		WAIT_ID,
		LISTEN,
		PUBLISH,
		RESEND,
		INHIBIT
	} ctrl_state_e;

endpackage
